// File: verilog/core_pkg.sv
package core_pkg;

	parameter int xlen = 64; // data path width.
	parameter int ilen = 32; // instruction width.

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111
	} opcode_t;

	// funct3 values.
	parameter logic [2:0] f3_add = 3'b000; // add, sub, addi.
	parameter logic [2:0] f3_slt = 3'b010;
	parameter logic [2:0] f3_xor = 3'b100;
	parameter logic [2:0] f3_or  = 3'b110;
	parameter logic [2:0] f3_and = 3'b111;
	parameter logic [2:0] f3_beq = 3'b000;
	parameter logic [2:0] f3_bne = 3'b001;
	parameter logic [2:0] f3_dw  = 3'b011; // ld and sd.

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_link
	} wb_sel_t;

	// execute operand source
	typedef enum logic [1:0] {
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_t;

endpackage

// File: verilog/regfile.sv
module regfile (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::reg_addr_t ra1,
	input  core_pkg::reg_addr_t ra2,
	input  logic                wen,
	input  core_pkg::reg_addr_t wa,
	input  core_pkg::word_t     wd,
	output core_pkg::word_t     rd1,
	output core_pkg::word_t     rd2
);

	core_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// write-first, so writeback is seen by decode in the same cycle.
	assign rd1 = (ra1 == '0) ? '0 : (wen && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (wen && wa == ra2) ? wd : regs[ra2];

endmodule

// File: verilog/decode.sv
module decode (
	input  logic [core_pkg::ilen-1:0] instr,
	input  core_pkg::word_t           pc,
	input  core_pkg::word_t           rd1,
	input  core_pkg::word_t           rd2,
	input  logic                      fwd_a,
	input  logic                      fwd_b,
	input  core_pkg::word_t           alu_out_m,
	output core_pkg::reg_addr_t       ra1,
	output core_pkg::reg_addr_t       ra2,
	output logic                      rs1_used,
	output logic                      rs2_used,
	output core_pkg::reg_addr_t       dst,
	output logic                      reg_write,
	output logic                      mem_read,
	output logic                      mem_write,
	output core_pkg::wb_sel_t         wb_sel,
	output core_pkg::alu_op_t         alu_op,
	output logic                      alu_src_imm,
	output core_pkg::word_t           imm,
	output core_pkg::word_t           op_a,
	output core_pkg::word_t           op_b,
	output logic                      branch_taken,
	output core_pkg::word_t           target
);

	core_pkg::opcode_t opcode;
	logic [2:0] funct3;
	core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	logic eq;

	assign opcode = core_pkg::opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign ra1 = instr[19:15];
	assign ra2 = instr[24:20];
	assign dst = instr[11:7];

	assign imm_i = {{(core_pkg::xlen-12){instr[31]}}, instr[31:20]};
	assign imm_s = {{(core_pkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{(core_pkg::xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
		instr[11:8], 1'b0};
	assign imm_u = {{(core_pkg::xlen-32){instr[31]}}, instr[31:12], 12'b0};
	assign imm_j = {{(core_pkg::xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20],
		instr[30:21], 1'b0};

	assign op_a = fwd_a ? alu_out_m : rd1; // early result for branches.
	assign op_b = fwd_b ? alu_out_m : rd2;
	assign eq = op_a == op_b;
	assign target = pc + imm;

	always_comb begin
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		wb_sel = core_pkg::wb_alu;
		alu_op = core_pkg::alu_add;
		alu_src_imm = 1'b0;
		imm = imm_i;
		rs1_used = 1'b0;
		rs2_used = 1'b0;
		branch_taken = 1'b0;
		case (opcode)
			core_pkg::opc_op: begin
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				reg_write = 1'b1;
				case (funct3)
					core_pkg::f3_add: alu_op = instr[30] ? core_pkg::alu_sub : core_pkg::alu_add;
					core_pkg::f3_slt: alu_op = core_pkg::alu_slt;
					core_pkg::f3_xor: alu_op = core_pkg::alu_xor;
					core_pkg::f3_or:  alu_op = core_pkg::alu_or;
					core_pkg::f3_and: alu_op = core_pkg::alu_and;
					default: reg_write = 1'b0;
				endcase
			end
			core_pkg::opc_op_imm: begin
				rs1_used = 1'b1;
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				case (funct3)
					core_pkg::f3_add: alu_op = core_pkg::alu_add;
					core_pkg::f3_xor: alu_op = core_pkg::alu_xor;
					core_pkg::f3_or:  alu_op = core_pkg::alu_or;
					core_pkg::f3_and: alu_op = core_pkg::alu_and;
					default: reg_write = 1'b0;
				endcase
			end
			core_pkg::opc_lui: begin
				reg_write = 1'b1;
				alu_op = core_pkg::alu_pass_b;
				alu_src_imm = 1'b1;
				imm = imm_u;
			end
			core_pkg::opc_load: begin
				rs1_used = funct3 == core_pkg::f3_dw;
				reg_write = funct3 == core_pkg::f3_dw;
				mem_read = funct3 == core_pkg::f3_dw;
				wb_sel = core_pkg::wb_mem;
				alu_src_imm = 1'b1;
			end
			core_pkg::opc_store: begin
				rs1_used = funct3 == core_pkg::f3_dw;
				rs2_used = funct3 == core_pkg::f3_dw;
				mem_write = funct3 == core_pkg::f3_dw;
				alu_src_imm = 1'b1;
				imm = imm_s;
			end
			core_pkg::opc_branch: begin
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				imm = imm_b;
				branch_taken = (funct3 == core_pkg::f3_beq && eq) ||
					(funct3 == core_pkg::f3_bne && !eq);
			end
			core_pkg::opc_jal: begin
				reg_write = 1'b1;
				wb_sel = core_pkg::wb_link;
				imm = imm_j;
				branch_taken = 1'b1;
			end
			default: ; // unknown, no-op.
		endcase
		if (dst == '0) reg_write = 1'b0; // x0 never written.
	end

endmodule

// File: verilog/execute.sv
module execute (
	input  core_pkg::word_t    op_a,
	input  core_pkg::word_t    op_b,
	input  core_pkg::word_t    imm,
	input  core_pkg::alu_op_t  alu_op,
	input  logic               alu_src_imm,
	input  core_pkg::fwd_sel_t fwd_a,
	input  core_pkg::fwd_sel_t fwd_b,
	input  core_pkg::word_t    alu_out_m,
	input  core_pkg::word_t    result_w,
	output core_pkg::word_t    alu_out,
	output core_pkg::word_t    store_data
);

	core_pkg::word_t a, b_reg, b;

	function automatic core_pkg::word_t pick(input core_pkg::fwd_sel_t sel,
		input core_pkg::word_t reg_val, input core_pkg::word_t mem_val,
		input core_pkg::word_t wb_val);
		core_pkg::word_t val;
		case (sel)
			core_pkg::fwd_mem: val = mem_val;
			core_pkg::fwd_wb:  val = wb_val;
			default:           val = reg_val;
		endcase
		return val;
	endfunction

	assign a = pick(fwd_a, op_a, alu_out_m, result_w);
	assign b_reg = pick(fwd_b, op_b, alu_out_m, result_w);
	assign b = alu_src_imm ? imm : b_reg;
	assign store_data = b_reg; // sd data is rs2.

	always_comb begin
		case (alu_op)
			core_pkg::alu_sub:    alu_out = a - b;
			core_pkg::alu_and:    alu_out = a & b;
			core_pkg::alu_or:     alu_out = a | b;
			core_pkg::alu_xor:    alu_out = a ^ b;
			core_pkg::alu_slt:    alu_out = {{(core_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
			core_pkg::alu_pass_b: alu_out = b; // lui.
			default:              alu_out = a + b;
		endcase
	end

endmodule

// File: verilog/hazard.sv
module hazard (
	input  core_pkg::reg_addr_t rs1_d,
	input  core_pkg::reg_addr_t rs2_d,
	input  logic                rs1_used_d,
	input  logic                rs2_used_d,
	input  logic                branch_d,
	input  core_pkg::reg_addr_t rs1_e,
	input  core_pkg::reg_addr_t rs2_e,
	input  core_pkg::reg_addr_t dst_e,
	input  logic                wr_e,
	input  logic                load_e,
	input  core_pkg::reg_addr_t dst_m,
	input  logic                wr_m,
	input  logic                load_m,
	input  core_pkg::reg_addr_t dst_w,
	input  logic                wr_w,
	input  logic                i_wait,
	input  logic                d_wait,
	input  logic                branch_taken,
	output logic                stall_f,
	output logic                stall_d,
	output logic                stall_e,
	output logic                stall_m,
	output logic                flush_d,
	output logic                flush_e,
	output logic                flush_w,
	output logic                fwd_a_d,
	output logic                fwd_b_d,
	output core_pkg::fwd_sel_t  fwd_a_e,
	output core_pkg::fwd_sel_t  fwd_b_e
);

	logic a_hit_e, b_hit_e, a_hit_m, b_hit_m;
	logic load_use, branch_wait;

	function automatic logic hit(input core_pkg::reg_addr_t rs, input logic used,
		input core_pkg::reg_addr_t dst, input logic wr);
		return used && wr && rs != '0 && dst == rs;
	endfunction

	function automatic core_pkg::fwd_sel_t src_e(input core_pkg::reg_addr_t rs,
		input core_pkg::reg_addr_t dm, input logic wm,
		input core_pkg::reg_addr_t dw, input logic ww);
		core_pkg::fwd_sel_t sel;
		if (hit(rs, 1'b1, dm, wm)) sel = core_pkg::fwd_mem; // newest value first.
		else if (hit(rs, 1'b1, dw, ww)) sel = core_pkg::fwd_wb;
		else sel = core_pkg::fwd_reg;
		return sel;
	endfunction

	assign a_hit_e = hit(rs1_d, rs1_used_d, dst_e, wr_e);
	assign b_hit_e = hit(rs2_d, rs2_used_d, dst_e, wr_e);
	assign a_hit_m = hit(rs1_d, rs1_used_d, dst_m, wr_m);
	assign b_hit_m = hit(rs2_d, rs2_used_d, dst_m, wr_m);

	assign load_use = load_e && (a_hit_e || b_hit_e);
	// load data reaches decode only through the regfile bypass.
	assign branch_wait = branch_d && (a_hit_e || b_hit_e || (load_m && (a_hit_m || b_hit_m)));

	assign stall_m = d_wait;
	assign stall_e = d_wait;
	assign stall_d = d_wait || load_use || branch_wait;
	assign stall_f = stall_d || i_wait;

	assign flush_d = branch_taken && !stall_d; // drop the wrong-path slot.
	assign flush_e = stall_d && !stall_e;
	assign flush_w = d_wait;

	assign fwd_a_d = a_hit_m && !load_m;
	assign fwd_b_d = b_hit_m && !load_m;
	assign fwd_a_e = src_e(rs1_e, dst_m, wr_m, dst_w, wr_w);
	assign fwd_b_e = src_e(rs2_e, dst_m, wr_m, dst_w, wr_w);

endmodule

// File: verilog/core.sv
module core #(
	parameter core_pkg::word_t RESET_PC = 64'h0000_0000_8000_0000
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      iresp_data_ok,
	input  logic [core_pkg::ilen-1:0] iresp_data,
	input  logic                      dresp_data_ok,
	input  core_pkg::word_t           dresp_data,
	output logic                      ireq_valid,
	output core_pkg::word_t           ireq_addr,
	output logic                      dreq_valid,
	output logic                      dreq_write,
	output core_pkg::word_t           dreq_addr,
	output core_pkg::word_t           dreq_wdata,
	output logic                      commit_valid,
	output core_pkg::word_t           commit_pc,
	output logic                      commit_wen,
	output core_pkg::reg_addr_t       commit_wa,
	output core_pkg::word_t           commit_wd
);

	logic started, req_done, i_wait, d_wait;
	core_pkg::word_t pc, redirect_pc, hold_pc, f_pc, d_pc;
	logic redirect_pend, hold_valid, f_valid, d_valid;
	logic [core_pkg::ilen-1:0] hold_instr, f_instr, d_instr, instr_d;
	core_pkg::reg_addr_t ra1, ra2, dst_d;
	logic rs1_used, rs2_used, reg_write_d, mem_read_d, mem_write_d, alu_src_imm_d;
	logic branch_d, branch_taken;
	core_pkg::wb_sel_t wb_sel_d;
	core_pkg::alu_op_t alu_op_d;
	core_pkg::word_t rd1, rd2, imm_d, op_a_d, op_b_d, target_d;
	logic stall_f, stall_d, stall_e, stall_m, flush_d, flush_e, flush_w, fwd_a_d, fwd_b_d;
	core_pkg::fwd_sel_t fwd_a_e, fwd_b_e;
	logic e_valid, e_reg_write, e_mem_read, e_mem_write, e_alu_src_imm;
	core_pkg::word_t e_pc, e_imm, e_op_a, e_op_b, alu_out_e, store_data_e;
	core_pkg::reg_addr_t e_dst, e_rs1, e_rs2;
	core_pkg::wb_sel_t e_wb_sel, m_wb_sel;
	core_pkg::alu_op_t e_alu_op;
	logic m_valid, m_reg_write, m_mem_read, m_mem_write, w_valid, w_wen;
	core_pkg::word_t m_pc, m_alu, m_store_data, m_result, w_pc, w_wd;
	core_pkg::reg_addr_t m_dst, w_wa;

	always_ff @(posedge clk) begin
		if (rst) started <= 1'b0;
		else started <= 1'b1; // first request one cycle after reset.
	end

	assign ireq_valid = started;
	assign ireq_addr = pc;
	assign req_done = ireq_valid && iresp_data_ok;
	assign i_wait = ireq_valid && !iresp_data_ok;

	// the address may only change once the pending request has completed
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
			redirect_pend <= 1'b0;
		end else if (req_done) begin
			if (flush_d) pc <= target_d;
			else if (redirect_pend) pc <= redirect_pc;
			else if (!hold_valid) pc <= pc + 64'd4; // else refetch same pc.
			redirect_pend <= 1'b0;
		end else if (flush_d) begin
			redirect_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (flush_d && !req_done) redirect_pc <= target_d;
	end

	always_ff @(posedge clk) begin
		if (rst || flush_d) hold_valid <= 1'b0;
		else if (hold_valid && !stall_d) hold_valid <= 1'b0;
		else if (req_done && !hold_valid && !redirect_pend && stall_f) hold_valid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!hold_valid) begin
			hold_pc <= pc;
			hold_instr <= iresp_data;
		end
	end

	assign f_valid = hold_valid || (req_done && !redirect_pend);
	assign f_pc = hold_valid ? hold_pc : pc;
	assign f_instr = hold_valid ? hold_instr : iresp_data;

	always_ff @(posedge clk) begin
		if (rst || flush_d) d_valid <= 1'b0;
		else if (!stall_d) d_valid <= f_valid;
	end

	always_ff @(posedge clk) begin
		if (!stall_d) begin
			d_pc <= f_pc;
			d_instr <= f_instr;
		end
	end

	assign instr_d = d_valid ? d_instr : '0; // bubble decodes as no-op.
	assign branch_d = instr_d[6:0] == core_pkg::opc_branch;

	regfile u_regfile (
		.clk(clk), .rst(rst), .ra1(ra1), .ra2(ra2),
		.wen(w_wen), .wa(w_wa), .wd(w_wd), .rd1(rd1), .rd2(rd2)
	);

	decode u_decode (
		.instr(instr_d), .pc(d_pc), .rd1(rd1), .rd2(rd2),
		.fwd_a(fwd_a_d), .fwd_b(fwd_b_d), .alu_out_m(m_result),
		.ra1(ra1), .ra2(ra2), .rs1_used(rs1_used), .rs2_used(rs2_used), .dst(dst_d),
		.reg_write(reg_write_d), .mem_read(mem_read_d), .mem_write(mem_write_d),
		.wb_sel(wb_sel_d), .alu_op(alu_op_d), .alu_src_imm(alu_src_imm_d), .imm(imm_d),
		.op_a(op_a_d), .op_b(op_b_d), .branch_taken(branch_taken), .target(target_d)
	);

	hazard u_hazard (
		.rs1_d(ra1), .rs2_d(ra2), .rs1_used_d(rs1_used), .rs2_used_d(rs2_used),
		.branch_d(branch_d), .rs1_e(e_rs1), .rs2_e(e_rs2), .dst_e(e_dst),
		.wr_e(e_reg_write), .load_e(e_mem_read), .dst_m(m_dst), .wr_m(m_reg_write),
		.load_m(m_mem_read), .dst_w(w_wa), .wr_w(w_wen), .i_wait(i_wait), .d_wait(d_wait),
		.branch_taken(branch_taken), .stall_f(stall_f), .stall_d(stall_d),
		.stall_e(stall_e), .stall_m(stall_m), .flush_d(flush_d), .flush_e(flush_e),
		.flush_w(flush_w), .fwd_a_d(fwd_a_d), .fwd_b_d(fwd_b_d),
		.fwd_a_e(fwd_a_e), .fwd_b_e(fwd_b_e)
	);

	always_ff @(posedge clk) begin
		if (rst || flush_e) begin
			e_valid <= 1'b0;
			e_reg_write <= 1'b0;
			e_mem_read <= 1'b0;
			e_mem_write <= 1'b0;
		end else if (!stall_e) begin
			e_valid <= d_valid;
			e_reg_write <= reg_write_d;
			e_mem_read <= mem_read_d;
			e_mem_write <= mem_write_d;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_e) begin
			e_pc <= d_pc;
			e_wb_sel <= wb_sel_d;
			e_dst <= dst_d;
			e_rs1 <= rs1_used ? ra1 : '0;
			e_rs2 <= rs2_used ? ra2 : '0;
			e_alu_op <= alu_op_d;
			e_alu_src_imm <= alu_src_imm_d;
			e_imm <= imm_d;
			e_op_a <= op_a_d;
			e_op_b <= op_b_d;
		end else begin
			// writeback turns into a bubble during a data wait, keep its value.
			if (fwd_a_e == core_pkg::fwd_wb) e_op_a <= w_wd;
			if (fwd_b_e == core_pkg::fwd_wb) e_op_b <= w_wd;
		end
	end

	execute u_execute (
		.op_a(e_op_a), .op_b(e_op_b), .imm(e_imm), .alu_op(e_alu_op),
		.alu_src_imm(e_alu_src_imm), .fwd_a(fwd_a_e), .fwd_b(fwd_b_e),
		.alu_out_m(m_result), .result_w(w_wd), .alu_out(alu_out_e), .store_data(store_data_e)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			m_valid <= 1'b0;
			m_reg_write <= 1'b0;
			m_mem_read <= 1'b0;
			m_mem_write <= 1'b0;
		end else if (!stall_m) begin
			m_valid <= e_valid;
			m_reg_write <= e_reg_write;
			m_mem_read <= e_mem_read;
			m_mem_write <= e_mem_write;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_m) begin
			m_pc <= e_pc;
			m_wb_sel <= e_wb_sel;
			m_dst <= e_dst;
			m_alu <= alu_out_e;
			m_store_data <= store_data_e;
		end
	end

	assign dreq_valid = m_mem_read || m_mem_write;
	assign dreq_write = m_mem_write;
	assign dreq_addr = m_alu;
	assign dreq_wdata = m_store_data;
	assign d_wait = dreq_valid && !dresp_data_ok;
	assign m_result = (m_wb_sel == core_pkg::wb_link) ? m_pc + 64'd4 : m_alu; // jal link.

	always_ff @(posedge clk) begin
		if (rst || flush_w) begin
			w_valid <= 1'b0;
			w_wen <= 1'b0;
		end else begin
			w_valid <= m_valid;
			w_wen <= m_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		w_pc <= m_pc;
		w_wa <= m_dst;
		w_wd <= (m_wb_sel == core_pkg::wb_mem) ? dresp_data : m_result;
	end

	assign commit_valid = w_valid;
	assign commit_pc = w_pc;
	assign commit_wen = w_wen;
	assign commit_wa = w_wa;
	assign commit_wd = w_wd;

endmodule

// File: sim/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// ISA-level interpreter, one entry per retired instruction.
function automatic void build_expected();
	logic [63:0] x [32];
	logic [63:0] mem [dmem_words];
	logic [63:0] pc, next_pc, a, b, res, addr;
	logic [63:0] imm_i, imm_s, imm_b, imm_j;
	logic [31:0] ins;
	logic [2:0] f3;
	logic [4:0] rd;
	logic wen, done;
	int steps;
	for (int i = 0; i < 32; i++) begin
		x[i] = '0;
	end
	for (int i = 0; i < dmem_words; i++) begin
		mem[i] = dmem_init[i];
	end
	pc = reset_pc;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 1000) begin
		ins = imem[word_index(pc)];
		f3 = ins[14:12];
		rd = ins[11:7];
		a = x[ins[19:15]];
		b = x[ins[24:20]];
		imm_i = {{52{ins[31]}}, ins[31:20]};
		imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		wen = 1'b0;
		res = '0;
		next_pc = pc + 64'd4;
		case (ins[6:0])
			core_pkg::opc_op, core_pkg::opc_op_imm: begin
				wen = 1'b1;
				if (ins[6:0] == core_pkg::opc_op_imm) b = imm_i;
				case (f3)
					3'b000: res = (ins[6:0] == core_pkg::opc_op && ins[30]) ? a - b : a + b;
					3'b010: res = {63'b0, $signed(a) < $signed(b)};
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					default: res = a & b;
				endcase
			end
			core_pkg::opc_lui: begin
				wen = 1'b1;
				res = {{32{ins[31]}}, ins[31:12], 12'b0};
			end
			core_pkg::opc_load: begin
				wen = 1'b1;
				addr = a + imm_i;
				res = mem[addr[10:3]];
			end
			core_pkg::opc_store: begin
				addr = a + imm_s;
				mem[addr[10:3]] = b;
			end
			core_pkg::opc_branch: begin
				if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) next_pc = pc + imm_b;
			end
			core_pkg::opc_jal: begin
				wen = 1'b1;
				res = pc + 64'd4;
				next_pc = pc + imm_j;
				if (imm_j == '0) done = 1'b1; // self-jump ends the program.
			end
			default: ;
		endcase
		if (rd == '0) wen = 1'b0;
		if (wen) x[rd] = res;
		exp_pc.push_back(pc);
		exp_wen.push_back(wen);
		exp_wa.push_back(rd);
		exp_wd.push_back(res);
		pc = next_pc;
		steps++;
	end
endfunction

`endif

// File: sim/tb_core.sv
module tb_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [63:0] reset_pc = 64'h0000_0000_8000_0000;
	localparam int imem_words = 64;
	localparam int dmem_words = 256;
	localparam int max_wait = 3;
	localparam int n_tests = 5;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic iresp_data_ok = 1'b0;
	logic [31:0] iresp_data = '0;
	logic dresp_data_ok = 1'b0;
	logic [63:0] dresp_data = '0;
	logic ireq_valid, dreq_valid, dreq_write, commit_valid, commit_wen;
	logic [63:0] ireq_addr, dreq_addr, dreq_wdata, commit_pc, commit_wd;
	logic [4:0] commit_wa;

	logic [31:0] imem [imem_words];
	logic [63:0] dmem [dmem_words];
	logic [63:0] dmem_init [dmem_words];
	logic [63:0] exp_pc [$];
	logic exp_wen [$];
	logic [4:0] exp_wa [$];
	logic [63:0] exp_wd [$];
	integer seed;
	int n_instr, wait_left, errors, commits, cur_test, limit_cycles;
	int test_errs [n_tests];
	int test_commits [n_tests];
	int test_first [n_tests] = '{0, 15, 20, 28, 41};
	logic run_done = 1'b0;

	core #(.RESET_PC(reset_pc)) UUT (
		.clk(clk), .rst(rst), .iresp_data_ok(iresp_data_ok), .iresp_data(iresp_data),
		.dresp_data_ok(dresp_data_ok), .dresp_data(dresp_data), .ireq_valid(ireq_valid),
		.ireq_addr(ireq_addr), .dreq_valid(dreq_valid), .dreq_write(dreq_write),
		.dreq_addr(dreq_addr), .dreq_wdata(dreq_wdata), .commit_valid(commit_valid),
		.commit_pc(commit_pc), .commit_wen(commit_wen), .commit_wa(commit_wa),
		.commit_wd(commit_wd)
	);

	function automatic int word_index(input logic [63:0] addr);
		logic [63:0] off;
		off = (addr - reset_pc) >> 2;
		return int'(off[5:0]);
	endfunction

	function automatic logic [31:0] rtype(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], core_pkg::opc_op};
	endfunction

	function automatic logic [31:0] itype(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] stype(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], core_pkg::opc_store};
	endfunction

	function automatic logic [31:0] btype(input int off, input int rs2, input int rs1,
		input int f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			core_pkg::opc_branch};
	endfunction

	function automatic logic [31:0] utype(input int imm, input int rd);
		return {imm[19:0], rd[4:0], core_pkg::opc_lui};
	endfunction

	function automatic logic [31:0] jtype(input int off, input int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], core_pkg::opc_jal};
	endfunction

	task automatic put(input logic [31:0] ins);
		imem[n_instr] = ins;
		n_instr++;
	endtask

	`include "ref_model.svh"

	task automatic load_program();
		for (int i = 0; i < imem_words; i++) begin
			imem[i] = '0;
		end
		n_instr = 0;
		put(itype(25, 0, 0, 1, core_pkg::opc_op_imm)); // arithmetic and logic.
		put(itype(-7, 0, 0, 2, core_pkg::opc_op_imm));
		put(rtype(0, 2, 1, 0, 3));
		put(rtype(32, 2, 1, 0, 4)); // sub.
		put(rtype(0, 2, 1, 7, 5));
		put(rtype(0, 2, 1, 6, 6));
		put(rtype(0, 2, 1, 4, 7));
		put(rtype(0, 1, 2, 2, 8)); // slt, negative first.
		put(rtype(0, 2, 1, 2, 9));
		put(itype(15, 3, 7, 10, core_pkg::opc_op_imm));
		put(itype(-256, 4, 6, 11, core_pkg::opc_op_imm));
		put(itype(85, 11, 4, 12, core_pkg::opc_op_imm));
		put(utype(20'h12345, 13));
		put(utype(20'h80000, 14));
		put(rtype(0, 14, 13, 0, 15));
		put(itype(1, 0, 0, 16, core_pkg::opc_op_imm)); // forwarding.
		put(rtype(0, 16, 16, 0, 16));
		put(itype(5, 16, 0, 0, core_pkg::opc_op_imm)); // x0 target.
		put(rtype(0, 1, 16, 0, 17));
		put(rtype(0, 17, 16, 0, 18));
		put(utype(1, 20)); // loads and stores.
		put(stype(8, 18, 20));
		put(itype(8, 20, 3, 21, core_pkg::opc_load));
		put(rtype(0, 1, 21, 0, 22)); // load-use.
		put(stype(16, 22, 20));
		put(itype(16, 20, 3, 23, core_pkg::opc_load));
		put(itype(32, 20, 3, 24, core_pkg::opc_load));
		put(rtype(0, 23, 24, 4, 25));
		put(itype(3, 0, 0, 26, core_pkg::opc_op_imm)); // control flow.
		put(btype(8, 0, 26, 0));
		put(btype(8, 0, 26, 1));
		put(itype(99, 0, 0, 27, core_pkg::opc_op_imm));
		put(btype(8, 26, 26, 0));
		put(itype(77, 0, 0, 27, core_pkg::opc_op_imm));
		put(btype(8, 26, 26, 1));
		put(jtype(8, 28));
		put(itype(55, 0, 0, 27, core_pkg::opc_op_imm));
		put(itype(8, 20, 3, 29, core_pkg::opc_load));
		put(btype(8, 18, 29, 0)); // branch right after a load.
		put(itype(11, 0, 0, 27, core_pkg::opc_op_imm));
		put(rtype(0, 29, 28, 0, 30));
		put(itype(4, 0, 0, 5, core_pkg::opc_op_imm)); // counted loop.
		put(itype(3, 6, 0, 6, core_pkg::opc_op_imm));
		put(itype(-1, 5, 0, 5, core_pkg::opc_op_imm));
		put(btype(-8, 0, 5, 1));
		put(jtype(0, 0));
	endtask

	function automatic int test_of(input logic [63:0] pc);
		int t;
		t = 0;
		for (int i = 1; i < n_tests; i++) begin
			if (word_index(pc) >= test_first[i]) t = i;
		end
		return t;
	endfunction

	task automatic report_test(input int t);
		$display("test %0d: %0d commits, %0d errors, %s", t + 1, test_commits[t], test_errs[t],
			(test_errs[t] == 0) ? "ok" : "FAILED");
	endtask

	task automatic note_error(input int t);
		test_errs[t]++;
		errors++;
	endtask

	task automatic check_commit();
		logic [63:0] e_pc, e_wd;
		logic e_wen;
		logic [4:0] e_wa;
		int t;
		if (exp_pc.size() == 0) begin
			$display("commit at pc %h arrived with no commit left in the model", commit_pc);
			errors++;
			run_done = 1'b1;
			return;
		end
		e_pc = exp_pc.pop_front();
		e_wen = exp_wen.pop_front();
		e_wa = exp_wa.pop_front();
		e_wd = exp_wd.pop_front();
		t = test_of(e_pc);
		if (t != cur_test) begin
			report_test(cur_test);
			cur_test = t;
		end
		commits++;
		test_commits[t]++;
		if (commit_pc !== e_pc) begin
			$display("ERROR commit_pc expected %h got %h", e_pc, commit_pc);
			note_error(t);
		end
		if (commit_wen !== e_wen) begin
			$display("ERROR commit_wen at pc %h expected %h got %h", e_pc, e_wen, commit_wen);
			note_error(t);
		end
		if (e_wen && commit_wa !== e_wa) begin
			$display("ERROR commit_wa at pc %h expected %h got %h", e_pc, e_wa, commit_wa);
			note_error(t);
		end
		if (e_wen && commit_wd !== e_wd) begin
			$display("ERROR commit_wd at pc %h expected %h got %h", e_pc, e_wd, commit_wd);
			note_error(t);
		end
		if (commit_wen && commit_wa == '0) begin
			$display("register x0 was written at pc %h", commit_pc);
			note_error(t);
		end
		if (exp_pc.size() == 0) run_done = 1'b1;
	endtask

	initial begin
		forever #50 clk = ~clk;
	end

	// instruction memory, one request answered every other cycle.
	always @(posedge clk) begin
		if (rst) begin
			iresp_data_ok <= 1'b0;
		end else if (ireq_valid && !iresp_data_ok) begin
			iresp_data_ok <= 1'b1;
			iresp_data <= imem[word_index(ireq_addr)];
		end else begin
			iresp_data_ok <= 1'b0;
		end
	end

	// data memory with 0 to max_wait random waits.
	always @(posedge clk) begin
		if (rst) begin
			dresp_data_ok <= 1'b0;
			wait_left <= 0;
		end else begin
			dresp_data_ok <= 1'b0;
			if (dreq_valid && !dresp_data_ok) begin
				if (wait_left == 0) begin
					dresp_data_ok <= 1'b1;
					dresp_data <= dmem[dreq_addr[10:3]];
					if (dreq_write) dmem[dreq_addr[10:3]] <= dreq_wdata;
					wait_left <= int'($unsigned($random(seed)) % (max_wait + 1));
				end else begin
					wait_left <= wait_left - 1;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (!rst && commit_valid && !run_done) check_commit();
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: no end of program after %0d cycles", limit_cycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		seed = 53346;
		errors = 0;
		commits = 0;
		cur_test = 0;
		for (int i = 0; i < n_tests; i++) begin
			test_errs[i] = 0;
			test_commits[i] = 0;
		end
		for (int i = 0; i < dmem_words; i++) begin
			dmem_init[i] = (64'h9e37_79b9_7f4a_7c15 * (i + 1)) ^ 64'(i);
			dmem[i] = dmem_init[i];
		end
		load_program();
		build_expected();
		limit_cycles = exp_pc.size() * 5 * 4 + 100;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		wait (run_done);
		report_test(cur_test);
		$display("%0d commits of %0d expected, %0d errors", commits, commits + exp_pc.size(),
			errors);
		if (errors == 0 && exp_pc.size() == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: build.f
verilog/core_pkg.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/hazard.sv
verilog/core.sv
+incdir+sim
sim/tb_core.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_core -f build.f -o sim_core \
	> build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "verilator build error, status $status"
	exit 1
fi

./obj_dir/sim_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
exit 1
